/* aes_round_core.f */
+incdir+rtl
+incdir+tests
rtl/aes_gf_pkg.sv
rtl/aes_round_pkg.sv
rtl/aes_row_shifter.sv
rtl/aes_gf256_inverter.sv
rtl/aes_sbox_lane.sv
rtl/aes_column_mixer.sv
rtl/aes_round_core.sv
tests/tb_aes_round_core.sv

/* rtl/aes_column_mixer.sv */
`include "aes_defs.svh"

module aes_column_mixer
	import aes_gf_pkg::*;
	import aes_round_pkg::*;
(
	input logic i_clk,
	input logic i_rst,
	input round_ctrl_t i_ctrl,
	input aes_state_t i_bytes,
	output logic o_valid,
	output aes_state_t o_state
);

	localparam int ROWS = `AES_NUM_BYTES / `AES_NUM_COLS;
	localparam int BW = `AES_BYTE_W;
	localparam int COL_W = ROWS * BW;

	round_ctrl_t ctrl_q;
	aes_state_t mixed;

	// lines up with the register inside the S-box lanes
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			ctrl_q <= '0;
		else
			ctrl_q <= i_ctrl;
	end

	always_comb
	begin
		aes_column_t col;
		aes_column_t col_out;
		gf_byte_t s [ROWS];
		gf_byte_t x2 [ROWS];
		gf_byte_t x4 [ROWS];
		gf_byte_t x8 [ROWS];
		gf_byte_t fwd;
		gf_byte_t inv;
		int r1;
		int r2;
		int r3;
		for (int c = 0; c < `AES_NUM_COLS; c++)
		begin
			col = i_bytes[(`AES_NUM_COLS-1-c)*COL_W +: COL_W];
			for (int r = 0; r < ROWS; r++)
			begin
				s[r] = col[(ROWS-1-r)*BW +: BW];
				x2[r] = xtime(s[r]);
				x4[r] = xtime(x2[r]);
				x8[r] = xtime(x4[r]);
			end
			for (int r = 0; r < ROWS; r++)
			begin
				r1 = (r + 1) % ROWS;
				r2 = (r + 2) % ROWS;
				r3 = (r + 3) % ROWS;
				// 2 3 1 1
				fwd = x2[r] ^ x2[r1] ^ s[r1] ^ s[r2] ^ s[r3];
				// e b d 9
				inv = (x8[r] ^ x4[r] ^ x2[r]) ^ (x8[r1] ^ x2[r1] ^ s[r1])
					^ (x8[r2] ^ x4[r2] ^ s[r2]) ^ (x8[r3] ^ s[r3]);
				if (ctrl_q.skip_mix)
					col_out[(ROWS-1-r)*BW +: BW] = s[r];
				else if (ctrl_q.decrypt)
					col_out[(ROWS-1-r)*BW +: BW] = inv;
				else
					col_out[(ROWS-1-r)*BW +: BW] = fwd;
			end
			mixed[(`AES_NUM_COLS-1-c)*COL_W +: COL_W] = col_out;
		end
	end

	always_ff @(posedge i_clk)
	begin
		o_state <= mixed;
		if (i_rst)
			o_valid <= 1'b0;
		else
			o_valid <= ctrl_q.valid;
	end

	a_state_known: assert property (@(posedge i_clk) disable iff (i_rst)
		o_valid |-> !$isunknown(o_state));

endmodule

/* rtl/aes_defs.svh */
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// bits per field element
`define AES_BYTE_W 8

// bytes in one 128-bit state
`define AES_NUM_BYTES 16

// state columns, four bytes each
`define AES_NUM_COLS 4

// low byte of x^8 + x^4 + x^3 + x + 1
`define AES_REDUCE_POLY 8'h1b

`endif

/* rtl/aes_gf256_inverter.sv */
module aes_gf256_inverter
	import aes_gf_pkg::*;
(
	input logic i_clk,
	input gf_byte_t i_elem,
	output gf_byte_t o_inv
);

	gf_nibble_sf_t a;
	gf_nibble_sf_t b;
	gf_nibble_t c;
	logic c1;
	logic c2;
	logic c3;
	gf_nibble_t d;

	gf_nibble_sf_t a_q;
	gf_nibble_sf_t b_q;
	gf_nibble_t d_q;
	gf_nibble_sf_t d_sf;
	gf_nibble_t p;
	gf_nibble_t q;

	// split over normal basis [d^16, d]
	assign a = gf4_factors(i_elem[7:4]);
	assign b = gf4_factors(i_elem[3:0]);

	// a*b + (a+b)^2 * nu, flattened
	assign c1 = ~(a.hi & b.hi);
	assign c2 = ~(a.sum[0] & b.sum[0]);
	assign c3 = ~(a.all & b.all);
	assign c[3] = ~(a.sum[0] | b.sum[0]) ^ ~(a.val[3] & b.val[3]) ^ c1 ^ c3;
	assign c[2] = ~(a.sum[1] | b.sum[1]) ^ ~(a.val[2] & b.val[2]) ^ c1 ^ c2;
	assign c[1] = ~(a.lo | b.lo) ^ ~(a.val[1] & b.val[1]) ^ c2 ^ c3;
	assign c[0] = ~(a.val[0] | b.val[0]) ^ ~(a.lo & b.lo) ^ ~(a.sum[1] & b.sum[1]) ^ c2;

	assign d = gf4_inv(c);

	// pipeline cut between the inverse and the products
	always_ff @(posedge i_clk)
	begin
		a_q <= a;
		b_q <= b;
		d_q <= d;
	end

	assign d_sf = gf4_factors(d_q);
	assign p = gf4_muls(d_sf, b_q);
	assign q = gf4_muls(d_sf, a_q);

	assign o_inv = {p, q};

endmodule

/* rtl/aes_gf_pkg.sv */
`include "aes_defs.svh"

package aes_gf_pkg;

	typedef logic [`AES_BYTE_W-1:0] gf_byte_t;
	typedef logic [3:0] gf_nibble_t;
	typedef logic [1:0] gf_pair_t;
	typedef logic [(`AES_NUM_BYTES/`AES_NUM_COLS)*`AES_BYTE_W-1:0] aes_column_t;
	// column-major, byte 0 in the top bits
	typedef logic [`AES_NUM_BYTES*`AES_BYTE_W-1:0] aes_state_t;

	// GF(2^4) element with the sums reused by the shared-factor multipliers
	typedef struct packed {
		gf_nibble_t val;
		gf_pair_t sum;
		logic hi;
		logic lo;
		logic all;
	} gf_nibble_sf_t;

	// square in GF(2^2), normal basis [W^2, W]
	function automatic gf_pair_t gf2_sq(gf_pair_t a);
		return {a[0], a[1]};
	endfunction

	// multiply in GF(2^2) given shared factors ab, cd
	function automatic gf_pair_t gf2_muls(gf_pair_t a, logic ab, gf_pair_t b, logic cd);
		logic abcd;
		abcd = ~(ab & cd);
		return {~(a[1] & b[1]) ^ abcd, ~(a[0] & b[0]) ^ abcd};
	endfunction

	// multiply and scale by N in GF(2^2)
	function automatic gf_pair_t gf2_muls_scl(gf_pair_t a, logic ab, gf_pair_t b, logic cd);
		logic t;
		t = ~(a[0] & b[0]);
		return {~(ab & cd) ^ t, ~(a[1] & b[1]) ^ t};
	endfunction

	function automatic gf_nibble_sf_t gf4_factors(gf_nibble_t x);
		gf_nibble_sf_t f;
		f.val = x;
		f.sum = x[3:2] ^ x[1:0];
		f.hi = x[3] ^ x[2];
		f.lo = x[1] ^ x[0];
		f.all = f.sum[1] ^ f.sum[0];
		return f;
	endfunction

	// multiply in GF(2^4)/GF(2^2), basis [alpha^8, alpha^2]
	function automatic gf_nibble_t gf4_muls(gf_nibble_sf_t x, gf_nibble_sf_t y);
		gf_pair_t ph;
		gf_pair_t pl;
		gf_pair_t p;
		ph = gf2_muls(x.val[3:2], x.hi, y.val[3:2], y.hi);
		pl = gf2_muls(x.val[1:0], x.lo, y.val[1:0], y.lo);
		p = gf2_muls_scl(x.sum, x.all, y.sum, y.all);
		return {ph ^ p, pl ^ p};
	endfunction

	// inverse in GF(2^4), the norm term folded into NAND/NOR form
	function automatic gf_nibble_t gf4_inv(gf_nibble_t x);
		gf_pair_t a;
		gf_pair_t b;
		gf_pair_t c;
		gf_pair_t d;
		logic sa;
		logic sb;
		logic sd;
		a = x[3:2];
		b = x[1:0];
		sa = a[1] ^ a[0];
		sb = b[1] ^ b[0];
		c = {~(a[1] | b[1]) ^ ~(sa & sb), ~(sa | sb) ^ ~(a[0] & b[0])};
		d = gf2_sq(c);
		sd = d[1] ^ d[0];
		return {gf2_muls(d, sd, b, sb), gf2_muls(d, sd, a, sa)};
	endfunction

	// inverting 2:1 byte select, picks a when s is set
	function automatic gf_byte_t gf_select_not(gf_byte_t a, gf_byte_t b, logic s);
		return ~(s ? a : b);
	endfunction

	function automatic gf_byte_t xtime(gf_byte_t b);
		return {b[`AES_BYTE_W-2:0], 1'b0} ^ (`AES_REDUCE_POLY & {`AES_BYTE_W{b[`AES_BYTE_W-1]}});
	endfunction

endpackage

/* rtl/aes_round_core.sv */
`include "aes_defs.svh"

module aes_round_core
	import aes_gf_pkg::*;
	import aes_round_pkg::*;
(
	input logic i_clk,
	input logic i_rst,
	input logic i_valid,
	input logic i_decrypt,
	input logic i_skip_mix,
	input aes_state_t i_state,
	output logic o_valid,
	output aes_state_t o_state
);

	localparam int BW = `AES_BYTE_W;

	round_stage_t stage1;
	aes_state_t lane_bytes;

	aes_row_shifter u_shifter (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_valid(i_valid),
		.i_decrypt(i_decrypt),
		.i_skip_mix(i_skip_mix),
		.i_state(i_state),
		.o_stage(stage1)
	);

	// byte k sits in the top bits for k = 0
	for (genvar k = 0; k < `AES_NUM_BYTES; k++)
	begin : g_lane
		aes_sbox_lane u_lane (
			.i_clk(i_clk),
			.i_decrypt(stage1.ctrl.decrypt),
			.i_byte(stage1.state[(`AES_NUM_BYTES-1-k)*BW +: BW]),
			.o_byte(lane_bytes[(`AES_NUM_BYTES-1-k)*BW +: BW])
		);
	end

	aes_column_mixer u_mixer (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_ctrl(stage1.ctrl),
		.i_bytes(lane_bytes),
		.o_valid(o_valid),
		.o_state(o_state)
	);

endmodule

/* rtl/aes_round_pkg.sv */
package aes_round_pkg;

	import aes_gf_pkg::*;

	// per-item control, sampled with the input strobe
	typedef struct packed {
		logic valid;
		logic decrypt;
		// final round has no column mixing
		logic skip_mix;
	} round_ctrl_t;

	// one item between pipeline stages
	typedef struct packed {
		round_ctrl_t ctrl;
		aes_state_t state;
	} round_stage_t;

endpackage

/* rtl/aes_row_shifter.sv */
`include "aes_defs.svh"

module aes_row_shifter
	import aes_gf_pkg::*;
	import aes_round_pkg::*;
(
	input logic i_clk,
	input logic i_rst,
	input logic i_valid,
	input logic i_decrypt,
	input logic i_skip_mix,
	input aes_state_t i_state,
	output round_stage_t o_stage
);

	localparam int ROWS = `AES_NUM_BYTES / `AES_NUM_COLS;
	localparam int COLS = `AES_NUM_COLS;
	localparam int BW = `AES_BYTE_W;

	aes_state_t shifted;

	// row r rotates left by r columns, right by r for the inverse
	always_comb
	begin
		for (int c = 0; c < COLS; c++)
		begin
			for (int r = 0; r < ROWS; r++)
			begin
				if (i_decrypt)
					shifted[(`AES_NUM_BYTES-1-(c*ROWS+r))*BW +: BW] =
						i_state[(`AES_NUM_BYTES-1-(((c+COLS-r)%COLS)*ROWS+r))*BW +: BW];
				else
					shifted[(`AES_NUM_BYTES-1-(c*ROWS+r))*BW +: BW] =
						i_state[(`AES_NUM_BYTES-1-(((c+r)%COLS)*ROWS+r))*BW +: BW];
			end
		end
	end

	always_ff @(posedge i_clk)
	begin
		o_stage.state <= shifted;
		o_stage.ctrl.decrypt <= i_decrypt;
		o_stage.ctrl.skip_mix <= i_skip_mix;
		if (i_rst)
			o_stage.ctrl.valid <= 1'b0;
		else
			o_stage.ctrl.valid <= i_valid;
	end

	a_valid_known: assert property (@(posedge i_clk) disable iff (i_rst)
		!$isunknown(o_stage.ctrl.valid));

endmodule

/* rtl/aes_sbox_lane.sv */
module aes_sbox_lane
	import aes_gf_pkg::*;
(
	input logic i_clk,
	input logic i_decrypt,
	input gf_byte_t i_byte,
	output gf_byte_t o_byte
);

	logic [9:1] r;
	logic [10:1] t;
	gf_byte_t in_enc;
	gf_byte_t in_dec;
	gf_byte_t in_sel;
	gf_byte_t inv;
	gf_byte_t out_enc;
	gf_byte_t out_dec;
	logic decrypt_q;

	// shared terms of the two input basis changes
	assign r[1] = i_byte[7] ^ i_byte[5];
	assign r[2] = i_byte[7] ~^ i_byte[4];
	assign r[3] = i_byte[6] ^ i_byte[0];
	assign r[4] = i_byte[5] ~^ r[3];
	assign r[5] = i_byte[4] ^ r[4];
	assign r[6] = i_byte[3] ^ i_byte[0];
	assign r[7] = i_byte[2] ^ r[1];
	assign r[8] = i_byte[1] ^ r[3];
	assign r[9] = i_byte[3] ^ r[8];

	// forward: basis change merged with the S-box bit matrix
	assign in_enc = {r[7] ~^ r[8], r[5], i_byte[1] ^ r[4], r[1] ~^ r[3],
		i_byte[1] ^ r[2] ^ r[6], ~i_byte[0], r[4], i_byte[2] ~^ r[9]};
	// inverse affine folded into the basis change
	assign in_dec = {r[2], i_byte[4] ^ r[8], i_byte[6] ^ i_byte[4], r[9],
		i_byte[6] ~^ r[2], r[7], i_byte[4] ^ r[6], i_byte[1] ^ r[5]};

	assign in_sel = gf_select_not(in_enc, in_dec, ~i_decrypt);

	aes_gf256_inverter u_inverter (
		.i_clk(i_clk),
		.i_elem(in_sel),
		.o_inv(inv)
	);

	// direction follows the inverter register
	always_ff @(posedge i_clk)
		decrypt_q <= i_decrypt;

	assign t[1] = inv[7] ^ inv[3];
	assign t[2] = inv[6] ^ inv[4];
	assign t[3] = inv[6] ^ inv[0];
	assign t[4] = inv[5] ~^ inv[3];
	assign t[5] = inv[5] ~^ t[1];
	assign t[6] = inv[5] ~^ inv[1];
	assign t[7] = inv[4] ~^ t[6];
	assign t[8] = inv[2] ^ t[4];
	assign t[9] = inv[1] ^ t[2];
	assign t[10] = t[3] ^ t[5];

	// basis return with the affine step
	assign out_enc = {t[4], t[1], t[3], t[5], t[2] ^ t[5], t[3] ^ t[8], t[7], t[9]};
	// plain basis return for the inverse S-box
	assign out_dec = {inv[4] ~^ inv[1], inv[1] ^ t[10], inv[2] ^ t[10], inv[6] ~^ inv[1],
		t[8] ^ t[9], inv[7] ~^ t[7], t[6], ~inv[2]};

	assign o_byte = gf_select_not(out_enc, out_dec, ~decrypt_q);

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the AES round testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_aes_round_core -f aes_round_core.f > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/Vtb_aes_round_core > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q -F '*** PASSED ***' sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1

/* tests/aes_ref_model.svh */
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// forward and inverse S-box, filled once before the run
logic [7:0] sbox_tab [256];
logic [7:0] inv_sbox_tab [256];

// product in GF(2^8), shift and add
function automatic logic [7:0] mul_bytes(logic [7:0] a, logic [7:0] b);
	logic [7:0] p;
	p = 8'h00;
	for (int i = 0; i < 8; i++)
	begin
		if (b[i])
			p = p ^ a;
		a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
	end
	return p;
endfunction

function automatic void fill_sbox_tables();
	logic [7:0] x;
	for (int i = 0; i < 256; i++)
	begin
		// multiplicative inverse by search, zero stays zero
		x = 8'h00;
		for (int j = 1; j < 256; j++)
			if (mul_bytes(8'(i), 8'(j)) == 8'h01)
				x = 8'(j);
		// affine step
		sbox_tab[i] = x ^ {x[6:0], x[7]} ^ {x[5:0], x[7:6]} ^ {x[4:0], x[7:5]}
			^ {x[3:0], x[7:4]} ^ 8'h63;
	end
	// inverse by searching for the matching input
	for (int v = 0; v < 256; v++)
		for (int i = 0; i < 256; i++)
			if (sbox_tab[i] == 8'(v))
				inv_sbox_tab[v] = 8'(i);
endfunction

// one round without AddRoundKey, byte k is row k%4 of column k/4
function automatic logic [127:0] expected_round(logic [127:0] s, logic dec, logic skip);
	logic [127:0] t;
	logic [127:0] m;
	logic [7:0] b;
	logic [31:0] coef;
	int src;
	for (int k = 0; k < 16; k++)
	begin
		src = dec ? (k + 16 - 4 * (k % 4)) % 16 : (k + 4 * (k % 4)) % 16;
		b = s[127 - 8*src -: 8];
		t[127 - 8*k -: 8] = dec ? inv_sbox_tab[b] : sbox_tab[b];
	end
	if (skip)
		return t;
	// circulant rows, 2 3 1 1 or e b d 9
	coef = dec ? 32'h0e0b0d09 : 32'h02030101;
	for (int k = 0; k < 16; k++)
	begin
		b = 8'h00;
		for (int j = 0; j < 4; j++)
			b = b ^ mul_bytes(coef[31 - 8*j -: 8],
				t[127 - 8*((k & ~3) + (k + j) % 4) -: 8]);
		m[127 - 8*k -: 8] = b;
	end
	return m;
endfunction

`endif

/* tests/tb_aes_round_core.sv */
module tb_aes_round_core;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	localparam int LATENCY = 3;
	localparam int TIMEOUT_CYCLES = 20;
	localparam int NUM_FIXED = 3;
	localparam int NUM_ROWS = NUM_FIXED + 8;

	typedef struct packed {
		logic [127:0] state;
		logic decrypt;
		logic skip_mix;
		logic [127:0] result;
	} vector_t;

	logic i_clk = 1'b0;
	logic i_rst;
	logic i_valid;
	logic i_decrypt;
	logic i_skip_mix;
	logic [127:0] i_state;
	logic o_valid;
	logic [127:0] o_state;

	vector_t vectors [NUM_ROWS];
	// completed clock periods, counted on the falling edge
	int cycle_no = 0;
	int due_cycle [$];
	logic [31:0] lcg_state = 32'hf769;

	`include "aes_ref_model.svh"

	aes_round_core i_dut (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_valid(i_valid),
		.i_decrypt(i_decrypt),
		.i_skip_mix(i_skip_mix),
		.i_state(i_state),
		.o_valid(o_valid),
		.o_state(o_state)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	always @(negedge i_clk)
		cycle_no <= cycle_no + 1;

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic string test_name(int i);
		return $sformatf("vector %0d %s%s", i, vectors[i].decrypt ? "decrypt" : "encrypt",
			vectors[i].skip_mix ? " without mix" : "");
	endfunction

	function automatic void build_vectors();
		logic [127:0] s;
		// FIPS-197 appendix B round 1, after MixColumns and after ShiftRows
		vectors[0] = {128'h193de3bea0f4e22b9ac68d2ae9f84808, 1'b0, 1'b0,
			128'h046681e5e0cb199a48f8d37a2806264c};
		vectors[1] = {128'h193de3bea0f4e22b9ac68d2ae9f84808, 1'b0, 1'b1,
			128'hd4bf5d30e0b452aeb84111f11e2798e5};
		// undoing those two steps gives back the round start
		vectors[2] = {128'hd4bf5d30e0b452aeb84111f11e2798e5, 1'b1, 1'b1,
			128'h193de3bea0f4e22b9ac68d2ae9f84808};
		for (int j = 0; j < NUM_ROWS - NUM_FIXED; j++)
		begin
			for (int w = 0; w < 4; w++)
				s[127 - 32*w -: 32] = next_rand();
			vectors[NUM_FIXED + j] = {s, j[0], j[1], expected_round(s, j[0], j[1])};
		end
	endfunction

	task automatic drive_vectors();
		int gap;
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			@(posedge i_clk);
			i_valid <= 1'b1;
			i_state <= vectors[i].state;
			i_decrypt <= vectors[i].decrypt;
			i_skip_mix <= vectors[i].skip_mix;
			due_cycle.push_back(cycle_no + LATENCY);
			// first rows back to back, then spaced by idle cycles
			gap = (i < 6) ? 0 : i % 3;
			for (int g = 0; g < gap; g++)
			begin
				@(posedge i_clk);
				i_valid <= 1'b0;
			end
		end
		@(posedge i_clk);
		i_valid <= 1'b0;
	endtask

	task automatic check_outputs();
		int waited;
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			waited = 0;
			@(negedge i_clk);
			while (o_valid !== 1'b1)
			begin
				assert (o_valid === 1'b0)
				else stop_with_failure("o_valid went unknown");
				waited++;
				assert (waited <= TIMEOUT_CYCLES)
				else stop_with_failure({"timed out waiting for o_valid of ", test_name(i)});
				@(negedge i_clk);
			end
			assert (due_cycle.size() > 0)
			else stop_with_failure("o_valid pulsed with no item in flight");
			assert (cycle_no == due_cycle[0])
			else stop_with_failure($sformatf("error %s latency: expected %0d, actual %0d",
				test_name(i), LATENCY, LATENCY + cycle_no - due_cycle[0]));
			assert (o_state === vectors[i].result)
			else stop_with_failure($sformatf("error %s: expected %h, actual %h",
				test_name(i), vectors[i].result, o_state));
			void'(due_cycle.pop_front());
		end
		for (int c = 0; c < RESET_CYCLES; c++)
		begin
			@(negedge i_clk);
			assert (o_valid === 1'b0)
			else stop_with_failure("o_valid pulsed after the last item");
		end
	endtask

	initial
	begin
		i_rst <= 1'b1;
		i_valid <= 1'b0;
		i_decrypt <= 1'b0;
		i_skip_mix <= 1'b0;
		i_state <= '0;
		fill_sbox_tables();
		build_vectors();
		// low from the first reset edge on
		for (int c = 0; c < RESET_CYCLES - 1; c++)
		begin
			@(negedge i_clk);
			assert (o_valid === 1'b0)
			else stop_with_failure("o_valid was not low during reset");
		end
		@(posedge i_clk);
		i_rst <= 1'b0;
		fork
			drive_vectors();
			check_outputs();
		join
		$display("*** PASSED ***");
		$finish;
	end

endmodule
